// File: src.f
verilog/led_cmd_pkg.sv
verilog/spi_byte_if.sv
verilog/led_cmd_rom.sv
verilog/led_cmd_sequencer.sv
verilog/spi_master_tx.sv
verilog/led_spi_top.sv
testbench/spi_slave_model.sv
testbench/tb_led_spi_top.sv

// File: Bender.yml
package:
  name: led_spi

sources:
  - verilog/led_cmd_pkg.sv
  - verilog/spi_byte_if.sv
  - verilog/led_cmd_rom.sv
  - verilog/led_cmd_sequencer.sv
  - verilog/spi_master_tx.sv
  - verilog/led_spi_top.sv
  - target: test
    files:
      - testbench/spi_slave_model.sv
      - testbench/tb_led_spi_top.sv

// File: testbench/tb_led_spi_top.sv
/* directed testbench for led_spi_top. Runs the whole command sequence once,
   records sck/ss_n activity with a monitor and checks it task by task */
`timescale 1ns/1ps
`default_nettype none

module tb_led_spi_top;

  import led_cmd_pkg::*;

  // expected run length: two startups, three ss-low waits, six bytes, done phase
  localparam int unsigned done_hold_cycles = 200;
  localparam int unsigned expected_cycles  = 2 * (startup_cycles + 1) +
    3 * (cs_setup_cycles + 1) + 6 * (sck_toggles + 1) * sck_half_cycles + done_hold_cycles;
  localparam int unsigned timeout_cycles   = 2 * expected_cycles; // close to 12000

  logic rst = 1'b0; // clock
  logic clk = 1'b1; // reset, held from time zero
  logic spi_sck;
  logic spi_mosi;
  logic spi_ss_n;
  logic tx_done;

  logic [7:0]  rx_byte;
  int unsigned rx_count;
  logic        frame_err;

  int unsigned cyc = 0; // rising clock edges since time zero
  int unsigned rel_cyc; // edge at which reset was released
  int unsigned value_errors = 0;
  int unsigned other_errors = 0;
  int unsigned seed_val;

  // monitor records, filled on the falling clock edge
  int unsigned ss_fall_q[$];
  int unsigned ss_rise_q[$];
  logic        sck_at_ss_edge_q[$];
  int unsigned phase_q[$];      // sck phase lengths in clocks
  logic [7:0]  byte_q[$];
  int unsigned byte_win_q[$];   // ss window each byte arrived in
  int unsigned win_edges [0:3]  = '{0, 0, 0, 0};
  int unsigned win = 0;         // ss low windows opened so far
  int unsigned sck_edges = 0;
  int unsigned sck_edges_ss_high = 0;
  int unsigned rises_in_win = 0;
  int unsigned last_edge_cyc = 0;
  int unsigned done_cyc = 0;
  logic        done_seen = 1'b0;
  logic        ss_prev = 1'b1;
  logic        sck_prev = 1'b0;
  int unsigned rx_prev = 0;

  led_spi_top u_led_spi_top (
    .rst      (rst),
    .clk      (clk),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_ss_n (spi_ss_n),
    .tx_done  (tx_done)
  );

  spi_slave_model u_spi_slave_model (
    .sck       (spi_sck),
    .mosi      (spi_mosi),
    .ss_n      (spi_ss_n),
    .rx_byte   (rx_byte),
    .rx_count  (rx_count),
    .frame_err (frame_err)
  );

  initial begin
    forever #20 rst = ~rst; // 40 ns period
  end

  always @(posedge rst) cyc <= cyc + 1;

  // outputs settle long before the falling edge
  always @(negedge rst) begin
    if (!clk) begin
      if (spi_ss_n !== ss_prev) begin
        sck_at_ss_edge_q.push_back(spi_sck);
        if (spi_ss_n) begin
          ss_rise_q.push_back(cyc);
        end else begin
          ss_fall_q.push_back(cyc);
          win++;
          rises_in_win = 0;
        end
      end
      if (spi_sck !== sck_prev) begin
        sck_edges++;
        if (spi_ss_n) sck_edges_ss_high++;
        win_edges[win]++;
        // the low phase before the first rise of a byte includes the handoff gap
        if (!spi_sck || (rises_in_win % 8 != 0)) phase_q.push_back(cyc - last_edge_cyc);
        if (spi_sck) rises_in_win++;
        last_edge_cyc = cyc;
      end
      if (rx_count != rx_prev) begin
        byte_q.push_back(rx_byte);
        byte_win_q.push_back(win);
      end
      if (tx_done && !done_seen) begin
        done_seen = 1'b1;
        done_cyc  = cyc;
      end
    end
    ss_prev  = spi_ss_n;
    sck_prev = spi_sck;
    rx_prev  = rx_count;
  end

  // SET_LED frame: address, type, led select, red, green, blue
  function automatic logic [7:0] frame_byte(input int unsigned idx);
    case (idx)
      0:       return 8'h08;
      1:       return 8'h06;
      2:       return 8'h02;
      3:       return 8'h10;
      4:       return 8'h1F;
      default: return 8'h00;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED at %0t: %s expected %0d (0x%0h), got %0d (0x%0h)",
             $time, name, exp, exp, act, act);
    value_errors++;
  endtask

  // random point inside the high half of the clock, well clear of the drive time
  task automatic sample_delay();
    int unsigned offs;
    offs = 3 + $urandom % 15;
    #(offs);
  endtask

  task automatic reset_and_startup();
    repeat (5) @(posedge rst);
    #2;
    if (spi_ss_n !== 1'b1) report_mismatch("spi_ss_n", 1, spi_ss_n);
    if (spi_sck !== 1'b0) report_mismatch("spi_sck", 0, spi_sck);
    if (tx_done !== 1'b0) report_mismatch("tx_done", 0, tx_done);
    clk     = 1'b0;
    rel_cyc = cyc;
    repeat (1 + $urandom % startup_cycles) @(posedge rst); // spot check mid startup
    sample_delay();
    if (spi_ss_n !== 1'b1) report_mismatch("spi_ss_n", 1, spi_ss_n);
    if (spi_sck !== 1'b0) report_mismatch("spi_sck", 0, spi_sck);
    while (ss_fall_q.size() == 0) @(posedge rst);
    if (ss_fall_q[0] - rel_cyc != startup_cycles + 1)
      report_mismatch("spi_ss_n fall cycle", startup_cycles + 1, ss_fall_q[0] - rel_cyc);
    if (win_edges[0] != 0) report_mismatch("spi_sck edges before ss", 0, win_edges[0]);
  endtask

  task automatic frame_content();
    int unsigned n;
    n = 0;
    while (ss_rise_q.size() == 0) @(posedge rst); // first window closed
    for (int unsigned i = 0; i < byte_q.size(); i++) begin
      if (byte_win_q[i] == 1) begin
        if (n < 6 && byte_q[i] !== frame_byte(n))
          report_mismatch("rx byte", frame_byte(n), byte_q[i]);
        n++;
      end
    end
    if (n != 6) report_mismatch("bytes in first window", 6, n);
    if (frame_err) begin
      $display("slave select rose in the middle of a byte");
      other_errors++;
    end
  endtask

  task automatic pause_window();
    int unsigned n;
    n = 0;
    while (ss_rise_q.size() < 2) @(posedge rst);
    if (ss_fall_q.size() != 2) report_mismatch("spi_ss_n falls", 2, ss_fall_q.size());
    if (ss_fall_q[1] - ss_rise_q[0] != startup_cycles + 1)
      report_mismatch("spi_ss_n high cycles", startup_cycles + 1, ss_fall_q[1] - ss_rise_q[0]);
    // setup time, then one check cycle that finds the end word
    if (ss_rise_q[1] - ss_fall_q[1] != cs_setup_cycles + 2)
      report_mismatch("spi_ss_n second window", cs_setup_cycles + 2,
                      ss_rise_q[1] - ss_fall_q[1]);
    if (win_edges[2] != 0) report_mismatch("spi_sck edges in second window", 0, win_edges[2]);
    foreach (byte_win_q[i]) if (byte_win_q[i] == 2) n++;
    if (n != 0) report_mismatch("bytes in second window", 0, n);
  endtask

  task automatic completion();
    int unsigned edges_before;
    while (!done_seen) @(posedge rst);
    if (done_cyc != ss_fall_q[1] + cs_setup_cycles + 2)
      report_mismatch("tx_done rise cycle", ss_fall_q[1] + cs_setup_cycles + 2, done_cyc);
    edges_before = sck_edges;
    repeat (done_hold_cycles) begin
      @(posedge rst);
      sample_delay();
      if (tx_done !== 1'b1) report_mismatch("tx_done", 1, tx_done);
      if (spi_ss_n !== 1'b1) report_mismatch("spi_ss_n", 1, spi_ss_n);
      if (spi_sck !== 1'b0) report_mismatch("spi_sck", 0, spi_sck);
    end
    if (sck_edges != edges_before)
      report_mismatch("spi_sck edges after done", edges_before, sck_edges);
    if (byte_q.size() != 6) report_mismatch("total bytes", 6, byte_q.size());
  endtask

  task automatic bit_rate_idle();
    if (phase_q.size() != 6 * (sck_toggles - 1))
      report_mismatch("sck phases measured", 6 * (sck_toggles - 1), phase_q.size());
    foreach (phase_q[i])
      if (phase_q[i] != sck_half_cycles)
        report_mismatch("spi_sck phase", sck_half_cycles, phase_q[i]);
    foreach (sck_at_ss_edge_q[i])
      if (sck_at_ss_edge_q[i] !== 1'b0)
        report_mismatch("spi_sck at ss edge", 0, sck_at_ss_edge_q[i]);
    if (sck_edges_ss_high != 0)
      report_mismatch("spi_sck edges with ss high", 0, sck_edges_ss_high);
    if (sck_edges != 6 * sck_toggles)
      report_mismatch("spi_sck edges", 6 * sck_toggles, sck_edges);
  endtask

  task automatic finish_run();
    $display("error counts: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    seed_val = $urandom(34);
    reset_and_startup();
    frame_content();
    pause_window();
    completion();
    bit_rate_idle(); // uses everything the monitor saw over the run
    finish_run();
  end

  initial begin
    wait (cyc >= timeout_cycles);
    $display("timeout, sequence not finished after %0d cycles", timeout_cycles);
    other_errors++;
    finish_run();
  end

endmodule

`default_nettype wire

// File: testbench/spi_slave_model.sv
/* passive SPI slave for the testbench. Shifts mosi in on rising sck while
   ss_n is low and presents every completed byte with a running count */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic              sck,
  input  logic              mosi,
  input  logic              ss_n,     // active low
  output logic [7:0]        rx_byte,  // last complete byte
  output int unsigned       rx_count, // bytes seen so far
  output logic              frame_err // ss_n rose in the middle of a byte
);

  logic [7:0]  shift;
  int unsigned bit_cnt;

  initial begin
    rx_byte   = 8'h00;
    rx_count  = 0;
    frame_err = 1'b0;
    shift     = 8'h00;
    bit_cnt   = 0;
  end

  // mode 0, MSB first
  always @(posedge sck) begin
    logic [7:0] nxt;
    nxt = {shift[6:0], mosi};
    if (!ss_n) begin
      shift <= nxt;
      if (bit_cnt == 7) begin
        bit_cnt  <= 0;
        rx_byte  <= nxt;
        rx_count <= rx_count + 1;
      end else begin
        bit_cnt <= bit_cnt + 1;
      end
    end
  end

  // deselect drops any partial byte
  always @(posedge ss_n) begin
    if (bit_cnt != 0) frame_err <= 1'b1;
    bit_cnt <= 0;
  end

endmodule

`default_nettype wire

// File: verilog/led_spi_top.sv
/* top level of the robot LED SPI link: command ROM, sequencer and byte
   transmitter. Drives sck, mosi and slave select and reports done */
`timescale 1ns/1ps
`default_nettype none

module led_spi_top (
  input  logic rst,      // clock
  input  logic clk,      // async reset, active high
  output logic spi_sck,
  output logic spi_mosi,
  output logic spi_ss_n, // active low
  output logic tx_done   // high once the end word is reached
);

  import led_cmd_pkg::*;

  rom_word_t rom_word;
  logic      rom_advance;

  spi_byte_if u_spi_bus ();

  led_cmd_rom u_led_cmd_rom (
    .rst     (rst),
    .clk     (clk),
    .advance (rom_advance),
    .word    (rom_word)
  );

  led_cmd_sequencer u_led_cmd_sequencer (
    .rst      (rst),
    .clk      (clk),
    .word     (rom_word),
    .advance  (rom_advance),
    .spi_ss_n (spi_ss_n),
    .tx_done  (tx_done),
    .bus      (u_spi_bus.ctrl)
  );

  spi_master_tx u_spi_master_tx (
    .rst  (rst),
    .clk  (clk),
    .bus  (u_spi_bus.tx),
    .sck  (spi_sck),
    .mosi (spi_mosi)
  );

endmodule

`default_nettype wire

// File: verilog/spi_master_tx.sv
/* SPI mode 0 byte transmitter, MSB first. Loads a byte on send, toggles
   sck on every bit_ena tick and drops busy after the 16th toggle */
`timescale 1ns/1ps
`default_nettype none

module spi_master_tx (
  input  logic   rst,  // clock
  input  logic   clk,  // async reset, active high
  spi_byte_if.tx bus,
  output logic   sck,  // idles low
  output logic   mosi  // changes after falling sck
);

  import led_cmd_pkg::*;

  logic [7:0]       shreg;    // bit 7 is on mosi
  logic [tog_w-1:0] tog_cnt;  // sck toggles done in this byte
  logic             last_tog; // this tick ends the byte

  assign last_tog = (tog_cnt == tog_w'(sck_toggles - 1));

  // busy, sck and toggle count
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      bus.busy <= 1'b0;
      sck      <= 1'b0;
      tog_cnt  <= '0;
    end else if (!bus.busy) begin
      tog_cnt <= '0;
      if (bus.send) begin
        bus.busy <= 1'b1; // visible the cycle after send
      end
    end else if (bus.bit_ena) begin
      sck     <= ~sck;
      tog_cnt <= tog_cnt + 1'b1;
      if (last_tog) begin
        bus.busy <= 1'b0; // 16th toggle leaves sck low
      end
    end
  end

  // shift register: load on send, shift on falling toggles
  always_ff @(posedge rst) begin
    if (!bus.busy && bus.send) begin
      shreg <= bus.data;
    end else if (bus.busy && bus.bit_ena && sck) begin
      // sck about to fall, next bit goes out with half a period to settle
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  assign mosi = bus.busy ? shreg[7] : 1'b0; // low while idle

  // idle level of mode 0, also holds when busy drops
  a_sck_low_idle: assert property (@(posedge rst) disable iff (clk)
    !bus.busy |-> !sck)
    else $error("sck high while the transmitter is idle");

endmodule

`default_nettype wire

// File: verilog/led_cmd_sequencer.sv
/* command FSM: waits for the slave to boot, drives slave select, hands ROM bytes
   to the transmitter and produces the sck bit-rate tick. Raises tx_done at the end */
`timescale 1ns/1ps
`default_nettype none

module led_cmd_sequencer (
  input  logic                   rst,      // clock
  input  logic                   clk,      // async reset, active high
  input  led_cmd_pkg::rom_word_t word,     // registered ROM output
  output logic                   advance,  // step the ROM address
  output logic                   spi_ss_n, // slave select, active low
  output logic                   tx_done,  // level, sequence finished
  spi_byte_if.ctrl               bus
);

  import led_cmd_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;
  rom_kind_e  word_kind;

  logic [delay_w-1:0] dly_cnt;
  logic [delay_w-1:0] dly_end; // end value picked by the state
  logic               dly_ena;
  logic               dly_done;

  logic [div_w-1:0] div_cnt;
  logic             div_end;

  assign word_kind = decode_word(word);
  assign bus.data  = word[7:0]; // only sampled on send, when word is a byte

  // Moore outputs
  assign spi_ss_n = (state == ST_STARTUP) || (state == ST_FINISH);
  assign tx_done  = (state == ST_FINISH);

  // which states wait, and for how long
  always_comb begin
    dly_ena = 1'b0;
    dly_end = delay_w'(cs_setup_cycles);
    case (state)
      ST_STARTUP: begin
        dly_ena = 1'b1;
        dly_end = delay_w'(startup_cycles);
      end
      ST_CS_SETUP, ST_CS_HOLD: begin
        dly_ena = 1'b1; // same setup time before and after a frame
      end
      default: begin
        dly_ena = 1'b0;
      end
    endcase
  end

  // counts 0..dly_end, so a timed state lasts dly_end + 1 clocks
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      dly_cnt <= '0;
    end else if (!dly_ena || dly_done) begin
      dly_cnt <= '0; // restarts from zero in the next timed state
    end else begin
      dly_cnt <= dly_cnt + 1'b1;
    end
  end

  assign dly_done = dly_ena && (dly_cnt == dly_end);

  // bit-rate divider, runs only while ss is low
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      div_cnt <= '0;
    end else if (spi_ss_n || div_end) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign div_end     = (div_cnt == div_w'(sck_half_cycles - 1));
  assign bus.bit_ena = !spi_ss_n && div_end; // one tick per sck half period

  // state register
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= ST_STARTUP;
    end else begin
      state <= state_nxt;
    end
  end

  // next state; send and advance are Mealy outputs of ST_CHECK
  always_comb begin
    state_nxt = state;
    bus.send  = 1'b0;
    advance   = 1'b0;
    case (state)
      ST_STARTUP: begin
        if (dly_done) state_nxt = ST_CS_SETUP; // ss falls here
      end
      ST_CS_SETUP: begin
        if (dly_done) state_nxt = ST_CHECK;
      end
      ST_CHECK: begin
        // wait for the transmitter in every case so sck is idle when ss moves
        if (!bus.busy) begin
          case (word_kind)
            ROM_SEND: begin
              bus.send  = 1'b1;
              advance   = 1'b1;
              state_nxt = ST_SEND;
            end
            ROM_PAUSE: begin
              advance   = 1'b1;
              state_nxt = ST_CS_HOLD;
            end
            default: begin
              state_nxt = ST_FINISH; // end word, ROM stays put
            end
          endcase
        end
      end
      ST_SEND: begin
        state_nxt = ST_CHECK; // new word is on the ROM output next cycle
      end
      ST_CS_HOLD: begin
        if (dly_done) state_nxt = ST_STARTUP;
      end
      ST_FINISH: begin
        state_nxt = ST_FINISH;
      end
      default: begin
        state_nxt = ST_STARTUP;
      end
    endcase
  end

  // a byte goes only to an idle transmitter, which must be busy one cycle later
  a_send_when_idle: assert property (@(posedge rst) disable iff (clk)
    bus.send |-> !bus.busy ##1 bus.busy)
    else $error("send while busy, or the transmitter did not take the byte");

  // done is sticky, with ss released and the transmitter idle
  a_done_ss_high: assert property (@(posedge rst) disable iff (clk)
    tx_done |-> (spi_ss_n && !bus.busy) ##1 tx_done)
    else $error("slave select low or transmitter busy after tx_done");

endmodule

`default_nettype wire

// File: verilog/led_cmd_rom.sv
/* fixed command ROM holding one SET_LED frame, a pause word and an end word.
   advance steps the address; word follows one clock after the address */
`timescale 1ns/1ps
`default_nettype none

module led_cmd_rom (
  input  logic                   rst,     // clock
  input  logic                   clk,     // async reset, active high
  input  logic                   advance, // step to the next word
  output led_cmd_pkg::rom_word_t word
);

  import led_cmd_pkg::*;

  logic [rom_addr_w-1:0] addr;
  rom_word_t             rom_data; // table output for the current address

  // address counter
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      addr <= '0;
    end else if (advance) begin
      addr <= addr + 1'b1;
    end
  end

  // SET_LED frame, then pause and end
  always_comb begin
    case (addr)
      6'h00:   rom_data = 9'h008; // slave address
      6'h01:   rom_data = 9'h006; // message type SET_LED
      6'h02:   rom_data = 9'h002; // led select, left eye
      6'h03:   rom_data = 9'h010; // red
      6'h04:   rom_data = 9'h01F; // green
      6'h05:   rom_data = 9'h000; // blue
      6'h06:   rom_data = rom_pause_word;
      6'h07:   rom_data = rom_end_word;
      default: rom_data = rom_end_word; // unused space reads as end
    endcase
  end

  // registered read so the table can go into block RAM
  always_ff @(posedge rst) begin
    word <= rom_data;
  end

  // the sequencer must stop at the end word and never step past it
  a_no_advance_at_end: assert property (@(posedge rst) disable iff (clk)
    advance |-> (word != rom_end_word))
    else $error("ROM advanced while the end word was on its output");

endmodule

`default_nettype wire

// File: verilog/spi_byte_if.sv
/* byte handoff between the command sequencer and the SPI transmitter.
   The sequencer uses the ctrl side, the transmitter the tx side */
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;

  logic       send;    // one-cycle strobe, only while busy is low
  logic [7:0] data;    // byte to shift out, valid with send
  logic       busy;    // high from the cycle after send to the end of the byte
  logic       bit_ena; // sck half-period tick from the sequencer divider

  // sequencer side
  modport ctrl (
    output send,
    output data,
    output bit_ena,
    input  busy
  );

  // transmitter side
  modport tx (
    input  send,
    input  data,
    input  bit_ena,
    output busy
  );

endinterface

`default_nettype wire

// File: verilog/led_cmd_pkg.sv
/* timing constants, ROM word format and FSM encodings for the LED command link.
   Compile it first; the RTL modules and the testbench import it */
`default_nettype none

package led_cmd_pkg;

  // delays in clocks, small values so simulation stays short
  localparam int unsigned startup_cycles  = 1500; // synthesis: 2**22 at 12 MHz, ~350 ms
  localparam int unsigned cs_setup_cycles = 500;  // synthesis: 2**16 at 12 MHz, ~5.5 ms
  localparam int unsigned sck_half_cycles = 12;   // 12 MHz / 24 gives a 500 kHz sck
  localparam int unsigned sck_toggles     = 16;   // two sck edges per bit, eight bits

  // the delay counter must hold the longest wait, startup is the longest
  localparam int unsigned delay_w = $clog2(startup_cycles + 1);
  localparam int unsigned div_w   = $clog2(sck_half_cycles);
  localparam int unsigned tog_w   = $clog2(sck_toggles);

  localparam int unsigned rom_addr_w = 6;

  // bit 8 clear: bits 7..0 are a byte for the slave
  // bit 8 set: control word, bit 0 picks pause (1) or end (0)
  typedef logic [8:0] rom_word_t;

  localparam rom_word_t rom_pause_word = 9'h101; // release ss, wait, start over
  localparam rom_word_t rom_end_word   = 9'h100; // stop for good

  typedef enum logic [1:0] {
    ROM_SEND,
    ROM_PAUSE,
    ROM_END
  } rom_kind_e;

  typedef enum logic [2:0] {
    ST_STARTUP,  // slave boots, ss high
    ST_CS_SETUP, // ss low before the first byte
    ST_CHECK,    // look at the current ROM word
    ST_SEND,     // one cycle for the registered word to catch up
    ST_CS_HOLD,  // ss kept low after the last byte of a frame
    ST_FINISH    // all done, stays here until reset
  } seq_state_e;

  // what the sequencer should do with a ROM word
  function automatic rom_kind_e decode_word(input rom_word_t w);
    rom_kind_e kind;
    if (!w[8]) begin
      kind = ROM_SEND;
    end else if (w[0]) begin
      kind = ROM_PAUSE;
    end else begin
      kind = ROM_END;
    end
    return kind;
  endfunction

endpackage

`default_nettype wire
